//--- Makefile
# Verilator build and run for the linked-list message bank

VERILATOR ?= verilator
TOP       ?= tb_ll_bank
RTL_TOP   ?= ll_bank
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall

SOURCES   := $(shell cat $(FILELIST))
RTL_FILES := $(filter verilog/%,$(SOURCES))
PASS_MSG  := ALL TESTS PASSED
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_FILES)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- sim/ll_bank_sva.sv
/*
 * Bound assertions for the message bank.
 * Release vector shape, no allocation while full and one RAM reader.
 */
`timescale 1ns/1ps

module ll_bank_sva (
  input logic                                            clk_i,
  input logic                                            rst_ni,
  input logic [ll_pkg::NumIds-1:0]                       release_i,
  input logic                                            alloc_i,
  input logic                                            full_i,
  input logic [ll_pkg::NumIds*(3+2*ll_pkg::AddrWidth)-1:0] req_i
);

  import ll_pkg::*;

  // Request word per ID is {rd, rd_addr, append, link, tail}
  localparam int ReqWidth = 3 + 2 * AddrWidth;

  logic [NumIds-1:0] rd_vec;

  int unsigned release_fails = 0;
  int unsigned alloc_fails = 0;
  int unsigned read_fails = 0;

  always_comb begin
    for (int n = 0; n < NumIds; n++) begin
      rd_vec[n] = req_i[n*ReqWidth + ReqWidth - 1];
    end
  end

  a_release_onehot : assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(release_i))
  else begin
    $error("release_i has more than one bit set");
    release_fails++;
  end

  a_no_alloc_full : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(alloc_i && full_i))
  else begin
    $error("slot allocated while the RAM is full");
    alloc_fails++;
  end

  a_one_reader : assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(rd_vec))
  else begin
    $error("more than one ID reads the RAM in one cycle");
    read_fails++;
  end

endmodule

bind ll_bank ll_bank_sva u_sva (
  .clk_i     (clk_i),
  .rst_ni    (rst_ni),
  .release_i (release_i),
  .alloc_i   (append_any),
  .full_i    (full),
  .req_i     (req)
);

//--- sim/tb_ll_bank.sv
/*
 * Testbench for the linked-list message bank.
 * Random traffic in fill, mixed and drain phases, checked against
 * one model queue per ID.
 */
`timescale 1ns/1ps

module tb_ll_bank;

  import ll_pkg::*;

  localparam logic [31:0] Seed = 32'h5d9e1937;
  localparam int ResetCycles = 10;
  localparam int FillCycles = 120;
  localparam int MixCycles = 600;
  localparam int DrainCycles = 100;
  localparam int TotalCycles = ResetCycles + FillCycles + MixCycles + DrainCycles;
  localparam int TimeoutCycles = 2 * TotalCycles;

  localparam int PhaseFill = 0;
  localparam int PhaseMix = 1;
  localparam int PhaseDrain = 2;

  logic                        clk_i = 1'b0;
  logic                        rst_ni;
  logic                        in_valid_i;
  msg_t                        in_msg_i;
  logic                        in_ready_o;
  logic [NumIds-1:0]           release_i;
  payload_t [NumIds-1:0]       buf_data_o;
  logic [NumIds-1:0]           buf_valid_o;

  // Reference model, one FIFO per ID with the buffer at the front
  payload_t          model_q [NumIds][$];
  logic [NumIds-1:0] pop_pending;
  logic              push_pending;
  msg_t              push_msg;

  int unsigned err_cnt;
  int unsigned check_cnt;
  int unsigned cycle_cnt = 0;
  bit          reached_full;
  int          last_rel_id;

  ll_bank uut (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .in_valid_i  (in_valid_i),
    .in_msg_i    (in_msg_i),
    .in_ready_o  (in_ready_o),
    .release_i   (release_i),
    .buf_data_o  (buf_data_o),
    .buf_valid_o (buf_valid_o)
  );

  always #5 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TimeoutCycles) begin
      $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  // Messages held in RAM, everything behind each buffer
  function automatic int ram_count();
    int total;
    total = 0;
    for (int n = 0; n < NumIds; n++) begin
      if (model_q[n].size() > 0) begin
        total += model_q[n].size() - 1;
      end
    end
    return total;
  endfunction

  // Pops first, then the push, as at the DUT's clock edge
  task automatic update_model();
    for (int n = 0; n < NumIds; n++) begin
      if (pop_pending[n]) begin
        void'(model_q[n].pop_front());
      end
    end
    if (push_pending) begin
      model_q[push_msg.id].push_back(push_msg.payload);
    end
  endtask

  task automatic drive_inputs(input int phase);
    logic [NumIds-1:0] rel_vec;
    int                id;
    rel_vec = '0;
    case (phase)
      PhaseFill: begin
        in_valid_i <= ($urandom % 100) < 90;
        if (($urandom % 10) == 0) begin
          rel_vec[$urandom % NumIds] = 1'b1;
        end
      end
      PhaseMix: begin
        in_valid_i <= ($urandom % 100) < 60;
        if (($urandom % 2) == 0) begin
          // Often repeat the last ID to get back-to-back releases
          id = (($urandom % 2) == 0) ? last_rel_id : int'($urandom % NumIds);
          rel_vec[id] = 1'b1;
          last_rel_id = id;
        end
      end
      default: begin
        in_valid_i <= 1'b0;
        // Stay on one ID until its list is empty
        if (model_q[last_rel_id].size() == 0) begin
          id = int'($urandom % NumIds);
          for (int k = 0; k < NumIds; k++) begin
            if (model_q[(id + k) % NumIds].size() > 0 &&
                model_q[last_rel_id].size() == 0) begin
              last_rel_id = (id + k) % NumIds;
            end
          end
        end
        if (model_q[last_rel_id].size() > 0) begin
          rel_vec[last_rel_id] = 1'b1;
        end
      end
    endcase
    in_msg_i.id      <= id_t'($urandom % NumIds);
    in_msg_i.payload <= payload_t'($urandom);
    release_i        <= rel_vec;
  endtask

  // Runs between edges, when all DUT outputs are settled
  task automatic check_outputs();
    logic exp_valid;
    logic exp_ready;
    for (int n = 0; n < NumIds; n++) begin
      exp_valid = (model_q[n].size() != 0);
      check_cnt++;
      if (buf_valid_o[n] !== exp_valid) begin
        err_cnt++;
        $display("Error: buf_valid_o[%0d] = 0x%0h, expected 0x%0h", n, buf_valid_o[n],
                 exp_valid);
      end
      pop_pending[n] = release_i[n] && exp_valid;
      if (pop_pending[n]) begin
        check_cnt++;
        if (buf_data_o[n] !== model_q[n][0]) begin
          err_cnt++;
          $display("Error: buf_data_o[%0d] = 0x%04h, expected 0x%04h", n, buf_data_o[n],
                   model_q[n][0]);
        end
      end
    end
    exp_ready = (ram_count() < Capacity);
    check_cnt++;
    if (in_ready_o !== exp_ready) begin
      err_cnt++;
      $display("Error: in_ready_o = 0x%0h, expected 0x%0h", in_ready_o, exp_ready);
    end
    if (!exp_ready) begin
      reached_full = 1'b1;
    end
    push_pending = in_valid_i && exp_ready;
    push_msg     = in_msg_i;
  endtask

  task automatic run_phase(input int phase, input int cycles);
    for (int c = 0; c < cycles; c++) begin
      @(posedge clk_i);
      update_model();
      drive_inputs(phase);
      @(negedge clk_i);
      check_outputs();
    end
  endtask

  initial begin
    void'($urandom(Seed));
    err_cnt      = 0;
    check_cnt    = 0;
    reached_full = 1'b0;
    last_rel_id  = 0;
    pop_pending  = '0;
    push_pending = 1'b0;
    push_msg     = '0;
    rst_ni       = 1'b0;
    in_valid_i   = 1'b0;
    in_msg_i     = '0;
    release_i    = '0;

    repeat (ResetCycles) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_cnt++;
    if (buf_valid_o !== '0) begin
      err_cnt++;
      $display("Error: buf_valid_o = 0x%0h after reset, expected 0x0", buf_valid_o);
    end
    if (in_ready_o !== 1'b1) begin
      err_cnt++;
      $display("Error: in_ready_o = 0x%0h after reset, expected 0x1", in_ready_o);
    end

    run_phase(PhaseFill, FillCycles);
    if (!reached_full) begin
      err_cnt++;
      $display("The fill phase never filled the RAM");
    end
    run_phase(PhaseMix, MixCycles);
    run_phase(PhaseDrain, DrainCycles);

    // Drain must leave nothing behind
    @(posedge clk_i);
    update_model();
    pop_pending  = '0;
    push_pending = 1'b0;
    release_i <= '0;
    @(negedge clk_i);
    check_cnt++;
    if (ram_count() != 0 || model_q[0].size() + model_q[1].size() +
        model_q[2].size() + model_q[3].size() != 0) begin
      err_cnt++;
      $display("The model queues are not empty after the drain phase");
    end
    if (buf_valid_o !== '0) begin
      err_cnt++;
      $display("Error: buf_valid_o = 0x%0h after drain, expected 0x0", buf_valid_o);
    end

    err_cnt += uut.u_sva.release_fails + uut.u_sva.alloc_fails + uut.u_sva.read_fails;
    $display("Checks: %0d, errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- src.f
verilog/ll_pkg.sv
verilog/ll_ram_2p.sv
verilog/ll_free_list.sv
verilog/ll_id_ctrl.sv
verilog/ll_bank.sv
sim/ll_bank_sva.sv
sim/tb_ll_bank.sv

//--- verilog/ll_bank.sv
/*
 * Linked-list message bank top level.
 * Routes accepted messages to their ID, merges the per-ID RAM requests
 * and connects the shared RAMs and the free-slot tracker.
 */
`timescale 1ns/1ps

module ll_bank (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  input  logic                                       in_valid_i,
  input  ll_pkg::msg_t                               in_msg_i,
  output logic                                       in_ready_o,
  input  logic [ll_pkg::NumIds-1:0]                  release_i,
  output ll_pkg::payload_t [ll_pkg::NumIds-1:0]      buf_data_o,
  output logic [ll_pkg::NumIds-1:0]                  buf_valid_o
);

  import ll_pkg::*;

  // RAM request bundle of one ID
  typedef struct packed {
    logic  rd;
    addr_t rd_addr;
    logic  append;
    logic  link;
    addr_t tail;
  } req_t;

  req_t [NumIds-1:0] req;
  logic [NumIds-1:0] accept;

  logic     rd_any;
  addr_t    rd_addr;
  logic     append_any;
  logic     link_any;
  addr_t    link_addr;
  addr_t    free_slot;
  logic     full;
  payload_t msg_rdata;
  addr_t    next_rdata;

  assign in_ready_o = !full;

  // Accept strobe goes only to the addressed ID
  always_comb begin
    for (int n = 0; n < NumIds; n++) begin
      accept[n] = in_valid_i && in_ready_o && (in_msg_i.id == id_t'(n));
    end
  end

  for (genvar n = 0; n < NumIds; n++) begin : g_id
    ll_id_ctrl u_id_ctrl (
      .clk_i        (clk_i),
      .rst_ni       (rst_ni),
      .accept_i     (accept[n]),
      .in_payload_i (in_msg_i.payload),
      .release_i    (release_i[n]),
      .free_slot_i  (free_slot),
      .msg_rdata_i  (msg_rdata),
      .next_rdata_i (next_rdata),
      .buf_data_o   (buf_data_o[n]),
      .buf_valid_o  (buf_valid_o[n]),
      .rd_o         (req[n].rd),
      .rd_addr_o    (req[n].rd_addr),
      .append_o     (req[n].append),
      .link_o       (req[n].link),
      .tail_o       (req[n].tail)
    );
  end

  // At most one ID reads and one ID writes per cycle, so OR-merging is safe
  always_comb begin
    rd_any     = 1'b0;
    rd_addr    = '0;
    append_any = 1'b0;
    link_any   = 1'b0;
    link_addr  = '0;
    for (int n = 0; n < NumIds; n++) begin
      rd_any     |= req[n].rd;
      append_any |= req[n].append;
      link_any   |= req[n].link;
      if (req[n].rd) begin
        rd_addr |= req[n].rd_addr;
      end
      if (req[n].link) begin
        link_addr |= req[n].tail;
      end
    end
  end

  ll_free_list u_free_list (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .alloc_i     (append_any),
    .free_i      (rd_any),
    .free_addr_i (rd_addr),
    .free_slot_o (free_slot),
    .full_o      (full)
  );

  // Message payloads, stored at the newly allocated slot
  ll_ram_2p #(
    .Width (PayloadWidth)
  ) u_msg_ram (
    .clk_i   (clk_i),
    .we_i    (append_any),
    .waddr_i (free_slot),
    .wdata_i (in_msg_i.payload),
    .re_i    (rd_any),
    .raddr_i (rd_addr),
    .rdata_o (msg_rdata)
  );

  // Next pointers, the old tail points at the new slot
  ll_ram_2p #(
    .Width (AddrWidth)
  ) u_next_ram (
    .clk_i   (clk_i),
    .we_i    (link_any),
    .waddr_i (link_addr),
    .wdata_i (free_slot),
    .re_i    (rd_any),
    .raddr_i (rd_addr),
    .rdata_o (next_rdata)
  );

endmodule

//--- verilog/ll_free_list.sv
/*
 * Free-slot tracker for the shared RAMs.
 * Keeps one occupancy bit per slot and offers the lowest free one.
 */
`timescale 1ns/1ps

module ll_free_list (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          alloc_i,
  input  logic          free_i,
  input  ll_pkg::addr_t free_addr_i,
  output ll_pkg::addr_t free_slot_o,
  output logic          full_o
);

  import ll_pkg::*;

  logic [Capacity-1:0] used_q;
  logic [Capacity-1:0] used_d;

  // Priority search, the lowest index wins
  always_comb begin
    free_slot_o = '0;
    for (int i = Capacity - 1; i >= 0; i--) begin
      if (!used_q[i]) begin
        free_slot_o = addr_t'(i);
      end
    end
  end

  assign full_o = &used_q;

  // Allocation and release may hit different slots in one cycle
  always_comb begin
    used_d = used_q;
    if (alloc_i) begin
      used_d[free_slot_o] = 1'b1;
    end
    if (free_i) begin
      used_d[free_addr_i] = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      used_q <= '0;
    end else begin
      used_q <= used_d;
    end
  end

endmodule

//--- verilog/ll_id_ctrl.sv
/*
 * Per-ID list control for the message bank.
 * Tracks head, tail and length of one linked list and drives the
 * one-entry output buffer, refilling it from RAM on release.
 */
`timescale 1ns/1ps

module ll_id_ctrl (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             accept_i,
  input  ll_pkg::payload_t in_payload_i,
  input  logic             release_i,
  input  ll_pkg::addr_t    free_slot_i,
  input  ll_pkg::payload_t msg_rdata_i,
  input  ll_pkg::addr_t    next_rdata_i,
  output ll_pkg::payload_t buf_data_o,
  output logic             buf_valid_o,
  output logic             rd_o,
  output ll_pkg::addr_t    rd_addr_o,
  output logic             append_o,
  output logic             link_o,
  output ll_pkg::addr_t    tail_o
);

  import ll_pkg::*;

  addr_t    head_q, head_d;
  addr_t    tail_q, tail_d;
  cnt_t     len_q, len_d;
  payload_t buf_q, buf_d;
  logic     valid_q, valid_d;

  // Set when the RAM read data of this cycle belongs to this ID
  logic     head_ram_q, head_ram_d;
  logic     buf_ram_q, buf_ram_d;

  addr_t    head_cur;
  payload_t buf_cur;
  logic     rel;
  logic     list_empty;
  logic     start_list;

  // Current head and buffer, taken from RAM right after a refill
  assign head_cur = head_ram_q ? next_rdata_i : head_q;
  assign buf_cur  = buf_ram_q ? msg_rdata_i : buf_q;

  assign buf_data_o  = buf_cur;
  assign buf_valid_o = valid_q;
  assign tail_o      = tail_q;

  assign rel        = release_i && valid_q;
  assign list_empty = (len_q == '0);

  // A release with entries behind the buffer pops the head
  assign rd_o      = rel && !list_empty;
  assign rd_addr_o = head_cur;

  // List is empty now or becomes empty by this release
  assign start_list = list_empty || (len_q == cnt_t'(1) && rel);

  always_comb begin
    head_d     = head_cur;
    tail_d     = tail_q;
    buf_d      = buf_cur;
    valid_d    = valid_q;
    head_ram_d = 1'b0;
    buf_ram_d  = 1'b0;
    append_o   = 1'b0;
    link_o     = 1'b0;

    if (rel) begin
      if (!list_empty) begin
        head_ram_d = 1'b1;
        buf_ram_d  = 1'b1;
      end else begin
        valid_d = 1'b0;
      end
    end

    if (accept_i) begin
      if (!valid_q) begin
        buf_d   = in_payload_i;
        valid_d = 1'b1;
      end else if (rel && list_empty) begin
        // Buffer drained and nothing queued, input refills it
        buf_d   = in_payload_i;
        valid_d = 1'b1;
      end else if (start_list) begin
        append_o   = 1'b1;
        head_d     = free_slot_i;
        tail_d     = free_slot_i;
        head_ram_d = 1'b0;
      end else begin
        append_o = 1'b1;
        link_o   = 1'b1;
        tail_d   = free_slot_i;
      end
    end

    len_d = len_q - cnt_t'(rd_o) + cnt_t'(append_o);
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      head_q     <= '0;
      tail_q     <= '0;
      len_q      <= '0;
      valid_q    <= 1'b0;
      head_ram_q <= 1'b0;
      buf_ram_q  <= 1'b0;
    end else begin
      head_q     <= head_d;
      tail_q     <= tail_d;
      len_q      <= len_d;
      valid_q    <= valid_d;
      head_ram_q <= head_ram_d;
      buf_ram_q  <= buf_ram_d;
    end
  end

  // Payload register
  always_ff @(posedge clk_i) begin
    buf_q <= buf_d;
  end

endmodule

//--- verilog/ll_pkg.sv
/*
 * Linked-list message bank shared definitions.
 * Sizes, field types and the incoming message layout.
 */
package ll_pkg;

  // ID space
  localparam int IdWidth = 2;
  localparam int NumIds = 2 ** IdWidth;

  // Shared RAM storage
  localparam int Capacity = 16;
  localparam int AddrWidth = $clog2(Capacity);

  // One extra bit so a list holding every slot still fits
  localparam int CntWidth = AddrWidth + 1;

  localparam int PayloadWidth = 16;

  typedef logic [IdWidth-1:0] id_t;
  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [CntWidth-1:0] cnt_t;
  typedef logic [PayloadWidth-1:0] payload_t;

  // Message as delivered at the input
  typedef struct packed {
    id_t      id;
    payload_t payload;
  } msg_t;

endpackage

//--- verilog/ll_ram_2p.sv
/*
 * Two-port RAM for the message bank.
 * One write port and one read port with one cycle of read latency.
 */
`timescale 1ns/1ps

module ll_ram_2p #(
  parameter int Width = 16
) (
  input  logic               clk_i,
  input  logic               we_i,
  input  ll_pkg::addr_t      waddr_i,
  input  logic [Width-1:0]   wdata_i,
  input  logic               re_i,
  input  ll_pkg::addr_t      raddr_i,
  output logic [Width-1:0]   rdata_o
);

  import ll_pkg::*;

  logic [Width-1:0] mem_q [Capacity];

  // Write port
  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem_q[waddr_i] <= wdata_i;
    end
  end

  // Registered read, data holds until the next read
  always_ff @(posedge clk_i) begin
    if (re_i) begin
      rdata_o <= mem_q[raddr_i];
    end
  end

endmodule
